// File: maze_wall_detector.f
+incdir+dv
design/maze_pkg.sv
design/wall_lookup_if.sv
design/maze_wall_map.sv
design/move_checker.sv
design/maze_wall_detector.sv
dv/maze_wall_detector_tb.sv

// File: dv/maze_maps.svh
/*
    Testbench copy of the five reference maze maps and the output model.
    Included inside the testbench module.
    Each nibble holds the walls of one cell, bit 0 up, 1 right, 2 down, 3 left.
*/
`ifndef MAZE_MAPS_SVH
`define MAZE_MAPS_SVH

// indexed [map][x][y]
localparam logic [3:0] REF_WALLS [5][6][6] = '{
    '{
        '{4'h6, 4'ha, 4'h2, 4'h2, 4'h3, 4'h7},
        '{4'hd, 4'h7, 4'hd, 4'h5, 4'h5, 4'h5},
        '{4'h6, 4'h9, 4'h6, 4'h9, 4'hc, 4'h9},
        '{4'hc, 4'h3, 4'h4, 4'h3, 4'h6, 4'h3},
        '{4'h7, 4'h5, 4'hd, 4'hc, 4'h9, 4'h5},
        '{4'hc, 4'h8, 4'ha, 4'ha, 4'ha, 4'h9}
    },
    '{
        '{4'h6, 4'ha, 4'ha, 4'h2, 4'h3, 4'h7},
        '{4'h5, 4'h6, 4'hb, 4'h5, 4'hc, 4'h1},
        '{4'hc, 4'h9, 4'h6, 4'h9, 4'h6, 4'h9},
        '{4'h6, 4'ha, 4'h9, 4'h6, 4'h9, 4'h7},
        '{4'hc, 4'hb, 4'h6, 4'h9, 4'h6, 4'h1},
        '{4'he, 4'ha, 4'h8, 4'ha, 4'h9, 4'hd}
    },
    '{
        '{4'h6, 4'ha, 4'ha, 4'ha, 4'ha, 4'h3},
        '{4'hc, 4'ha, 4'ha, 4'h3, 4'h6, 4'h9},
        '{4'h6, 4'ha, 4'ha, 4'h9, 4'hc, 4'hb},
        '{4'h5, 4'h6, 4'ha, 4'ha, 4'ha, 4'h3},
        '{4'h5, 4'hc, 4'ha, 4'h2, 4'hb, 4'h5},
        '{4'hc, 4'ha, 4'ha, 4'h9, 4'he, 4'h9}
    },
    '{
        '{4'he, 4'ha, 4'h2, 4'ha, 4'h2, 4'h3},
        '{4'h6, 4'h3, 4'h5, 4'h7, 4'h5, 4'h5},
        '{4'hd, 4'h5, 4'h4, 4'h9, 4'h5, 4'h5},
        '{4'h7, 4'h5, 4'h5, 4'h6, 4'h9, 4'hd},
        '{4'h5, 4'h5, 4'hd, 4'hc, 4'ha, 4'h3},
        '{4'hc, 4'h8, 4'ha, 4'ha, 4'ha, 4'h9}
    },
    '{
        '{4'h6, 4'ha, 4'ha, 4'h3, 4'he, 4'h3},
        '{4'h5, 4'h7, 4'he, 4'h9, 4'h6, 4'h1},
        '{4'h5, 4'h4, 4'h3, 4'h6, 4'h1, 4'h5},
        '{4'h5, 4'h5, 4'h5, 4'hd, 4'h5, 4'h5},
        '{4'hc, 4'h9, 4'hc, 4'h3, 4'h5, 4'h5},
        '{4'he, 4'ha, 4'ha, 4'h8, 4'h9, 4'hd}
    }
};

// expected {enable_move, error} for one input cycle
function automatic logic [1:0] predict_outputs(
    logic [2:0] mode,
    logic       stb,
    logic [5:0] btn,
    logic [2:0] sel,
    logic       cleared,
    logic [2:0] x,
    logic [2:0] y
);
    logic [3:0] walls;
    int         side;
    if (mode != 3'd1 || !stb || cleared) begin
        return 2'b00;
    end
    case (btn)
        6'b000010: side = 0;
        6'b000100: side = 1;
        6'b001000: side = 2;
        6'b010000: side = 3;
        default:   return 2'b00;
    endcase
    // unknown map or off-grid cell is closed on every side
    if (sel < 3'd5 && x < 3'd6 && y < 3'd6) begin
        walls = REF_WALLS[sel][x][y];
    end else begin
        walls = 4'hf;
    end
    return {!walls[side], walls[side]};
endfunction

`endif

// File: dv/maze_wall_detector_tb.sv
/*
    Testbench for the maze wall detector.
    Drives reset, random and swept direction presses, gating and invalid
    lookups; concurrent assertions compare the outputs with a model.
*/
`timescale 1ns/1ps

module maze_wall_detector_tb;

    `include "maze_maps.svh"

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 8;
    localparam int RANDOM_PER_MAP = 8;
    localparam int SWEEP_CYCLES   = 5 * 6 * 6 * 4;
    localparam int MISC_CYCLES    = 64;
    localparam int MARGIN_CYCLES  = 200;
    localparam int TOTAL_CYCLES   = RESET_CYCLES + 2 * 5 * RANDOM_PER_MAP +
                                    SWEEP_CYCLES + MISC_CYCLES + MARGIN_CYCLES;

    logic                 clk;
    logic                 rst_n;
    maze_pkg::play_mode_t play_mode;
    logic                 strobe;
    maze_pkg::button_t    button;
    maze_pkg::map_sel_t   map_select;
    logic                 maze_cleared;
    maze_pkg::coord_t     pos_x;
    maze_pkg::coord_t     pos_y;
    logic                 enable_move;
    logic                 error;

    logic   exp_enable;
    logic   exp_error;
    int     test_id;
    int     exp_id;
    integer seed;

    maze_wall_detector dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .play_mode    (play_mode),
        .strobe       (strobe),
        .button       (button),
        .map_select   (map_select),
        .maze_cleared (maze_cleared),
        .pos_x        (pos_x),
        .pos_y        (pos_y),
        .enable_move  (enable_move),
        .error        (error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic string name_of(int id);
        case (id)
            1:       return "open_moves";
            2:       return "blocked_moves";
            3:       return "full_sweep";
            4:       return "non_direction";
            5:       return "gating";
            6:       return "invalid_lookup";
            default: return "reset_idle";
        endcase
    endfunction

    function automatic maze_pkg::button_t dir_button(int d);
        return maze_pkg::button_t'(6'b000010 << d);
    endfunction

    task automatic stop_on_failure(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(int id, string sig, logic expv, logic act);
        $display("Mismatch test=%s %s expected=%0b actual=%0b", name_of(id), sig, expv, act);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // model output lags the sampled inputs by one clock
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_enable <= 1'b0;
            exp_error  <= 1'b0;
        end else begin
            {exp_enable, exp_error} <= predict_outputs(play_mode, strobe, button,
                                                       map_select, maze_cleared,
                                                       pos_x, pos_y);
        end
        exp_id <= test_id;
    end

    check_reset: assert property (@(posedge clk)
        !rst_n |=> (enable_move === 1'b0 && error === 1'b0))
        else report_mismatch(0, "outputs", 1'b0, $sampled(enable_move | error));

    check_enable: assert property (@(posedge clk) enable_move === exp_enable)
        else report_mismatch($sampled(exp_id), "enable_move",
                             $sampled(exp_enable), $sampled(enable_move));

    check_error: assert property (@(posedge clk) error === exp_error)
        else report_mismatch($sampled(exp_id), "error",
                             $sampled(exp_error), $sampled(error));

    check_exclusive: assert property (@(posedge clk)
        !(enable_move === 1'b1 && error === 1'b1))
        else stop_on_failure("enable_move and error were high in the same cycle");

    task automatic drive_cycle(int id, maze_pkg::play_mode_t mode, logic stb,
                               maze_pkg::button_t btn, maze_pkg::map_sel_t sel,
                               logic cleared, maze_pkg::coord_t x, maze_pkg::coord_t y);
        @(posedge clk);
        test_id      <= id;
        play_mode    <= mode;
        strobe       <= stb;
        button       <= btn;
        map_select   <= sel;
        maze_cleared <= cleared;
        pos_x        <= x;
        pos_y        <= y;
    endtask

    task automatic idle_cycle();
        drive_cycle(0, maze_pkg::MODE_SELECT, 1'b0, maze_pkg::BTN_NONE, 3'd0, 1'b0, 3'd0, 3'd0);
    endtask

    // random cells on each map whose wall bit matches want_wall
    task automatic run_random_moves(logic want_wall);
        int m;
        int n;
        int x;
        int y;
        int d;
        int tries;
        for (m = 0; m < 5; m++) begin
            for (n = 0; n < RANDOM_PER_MAP; n++) begin
                tries = 0;
                do begin
                    x = $unsigned($random(seed)) % 6;
                    y = $unsigned($random(seed)) % 6;
                    d = $unsigned($random(seed)) % 4;
                    tries++;
                end while (REF_WALLS[m][x][y][d] != want_wall && tries < 1000);
                if (REF_WALLS[m][x][y][d] != want_wall) begin
                    stop_on_failure("no matching cell found for a random move");
                end
                drive_cycle(want_wall ? 2 : 1, maze_pkg::MAZE, 1'b1, dir_button(d),
                            m, 1'b0, x, y);
            end
        end
    endtask

    task automatic run_sweep();
        for (int m = 0; m < 5; m++) begin
            for (int x = 0; x < 6; x++) begin
                for (int y = 0; y < 6; y++) begin
                    for (int d = 0; d < 4; d++) begin
                        drive_cycle(3, maze_pkg::MAZE, 1'b1, dir_button(d), m, 1'b0, x, y);
                    end
                end
            end
        end
    endtask

    task automatic run_non_direction();
        maze_pkg::button_t btn;
        drive_cycle(4, maze_pkg::MAZE, 1'b1, maze_pkg::BTN_SELECT, 3'd0, 1'b0, 3'd1, 3'd1);
        drive_cycle(4, maze_pkg::MAZE, 1'b1, maze_pkg::BTN_BACK, 3'd2, 1'b0, 3'd3, 3'd2);
        drive_cycle(4, maze_pkg::MAZE, 1'b1, maze_pkg::BTN_NONE, 3'd6, 1'b0, 3'd0, 3'd0);
        drive_cycle(4, maze_pkg::MAZE, 1'b1, 6'b001010, 3'd1, 1'b0, 3'd0, 3'd0);
        drive_cycle(4, maze_pkg::MAZE, 1'b1, 6'b111111, 3'd4, 1'b0, 3'd7, 3'd2);
        for (int i = 0; i < 6; i++) begin
            do begin
                btn = maze_pkg::button_t'($random(seed));
            end while ($countones(btn) < 2);
            drive_cycle(4, maze_pkg::MAZE, 1'b1, btn, i % 5, 1'b0, i, 5 - i);
        end
    endtask

    task automatic run_gating();
        maze_pkg::play_mode_t other;
        for (int d = 0; d < 4; d++) begin
            other = maze_pkg::play_mode_t'(3'd2 + ($unsigned($random(seed)) % 6));
            drive_cycle(5, maze_pkg::MODE_SELECT, 1'b1, dir_button(d), 3'd0, 1'b0, 3'd0, 3'd0);
            drive_cycle(5, other, 1'b1, dir_button(d), 3'd1, 1'b0, 3'd2, 3'd3);
            drive_cycle(5, maze_pkg::MAZE, 1'b0, dir_button(d), 3'd6, 1'b0, 3'd1, 3'd4);
            drive_cycle(5, maze_pkg::MAZE, 1'b1, dir_button(d), 3'd3, 1'b1, 3'd5, 3'd5);
        end
    endtask

    task automatic run_invalid();
        for (int d = 0; d < 4; d++) begin
            for (int m = 5; m < 8; m++) begin
                drive_cycle(6, maze_pkg::MAZE, 1'b1, dir_button(d), m, 1'b0, 3'd2, 3'd2);
            end
            drive_cycle(6, maze_pkg::MAZE, 1'b1, dir_button(d), 3'd0, 1'b0, 3'd6, 3'd1);
            drive_cycle(6, maze_pkg::MAZE, 1'b1, dir_button(d), 3'd2, 1'b0, 3'd7, 3'd4);
            drive_cycle(6, maze_pkg::MAZE, 1'b1, dir_button(d), 3'd3, 1'b0, 3'd0, 3'd6);
            drive_cycle(6, maze_pkg::MAZE, 1'b1, dir_button(d), 3'd4, 1'b0, 3'd5, 3'd7);
        end
    endtask

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD);
        stop_on_failure("run did not finish before the watchdog limit");
    end

    initial begin
        seed         = 32'hcf9c;
        clk          = 1'b0;
        test_id      = 0;
        rst_n        <= 1'b0;
        // qualified presses during reset, blocked and open in turn
        play_mode    <= maze_pkg::MAZE;
        strobe       <= 1'b1;
        button       <= maze_pkg::BTN_RIGHT;
        map_select   <= 3'd0;
        maze_cleared <= 1'b0;
        pos_x        <= 3'd0;
        pos_y        <= 3'd0;
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            drive_cycle(0, maze_pkg::MAZE, 1'b1,
                        (i % 2 == 0) ? maze_pkg::BTN_UP : maze_pkg::BTN_RIGHT,
                        3'd0, 1'b0, 3'd0, 3'd0);
        end
        idle_cycle();
        rst_n <= 1'b1;
        run_random_moves(1'b0);
        run_random_moves(1'b1);
        run_sweep();
        run_non_direction();
        run_gating();
        run_invalid();
        // let the last result reach the checks
        repeat (3) idle_cycle();
        $display("TEST OK");
        $finish;
    end

endmodule

// File: design/maze_wall_detector.sv
/*
    Top level of the maze wall detector.
    A qualified direction press gives enable_move when the side is open,
    or error when a wall stands there, one clock after the strobe.
*/
`timescale 1ns/1ps

module maze_wall_detector (
    input  logic                 clk,
    input  logic                 rst_n,
    input  maze_pkg::play_mode_t play_mode,
    input  logic                 strobe,
    input  maze_pkg::button_t    button,
    input  maze_pkg::map_sel_t   map_select,
    input  logic                 maze_cleared,
    input  maze_pkg::coord_t     pos_x,
    input  maze_pkg::coord_t     pos_y,
    output logic                 enable_move,
    output logic                 error
);

    // combinational cell lookup, same cycle
    wall_lookup_if lookup ();

    move_checker u_move_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .play_mode    (play_mode),
        .strobe       (strobe),
        .button       (button),
        .map_select   (map_select),
        .maze_cleared (maze_cleared),
        .pos_x        (pos_x),
        .pos_y        (pos_y),
        .lookup       (lookup.requester),
        .enable_move  (enable_move),
        .error        (error)
    );

    maze_wall_map u_maze_wall_map (
        .lookup (lookup.responder)
    );

endmodule

// File: design/move_checker.sv
/*
    Qualifies a button strobe during the maze game and tests the
    wall on the pressed side of the current cell.
    Grants the move or flags an error one clock after the strobe.
*/
`timescale 1ns/1ps

module move_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  maze_pkg::play_mode_t play_mode,
    input  logic                 strobe,
    input  maze_pkg::button_t    button,
    input  maze_pkg::map_sel_t   map_select,
    input  logic                 maze_cleared,
    input  maze_pkg::coord_t     pos_x,
    input  maze_pkg::coord_t     pos_y,
    wall_lookup_if.requester     lookup,
    output logic                 enable_move,
    output logic                 error
);

    maze_pkg::dir_e dir;
    logic           is_dir;
    logic           qualified;
    logic           wall_hit;

    // current cell goes straight to the wall map
    assign lookup.map_sel = map_select;
    assign lookup.pos_x   = pos_x;
    assign lookup.pos_y   = pos_y;

    // only an exact one-hot direction code counts
    always_comb begin
        dir    = maze_pkg::UP;
        is_dir = 1'b1;
        case (button)
            maze_pkg::BTN_UP:    dir = maze_pkg::UP;
            maze_pkg::BTN_RIGHT: dir = maze_pkg::RIGHT;
            maze_pkg::BTN_DOWN:  dir = maze_pkg::DOWN;
            maze_pkg::BTN_LEFT:  dir = maze_pkg::LEFT;
            default:             is_dir = 1'b0;
        endcase
    end

    assign qualified = (play_mode == maze_pkg::MAZE) && strobe && !maze_cleared;
    assign wall_hit  = lookup.walls[dir];

    // one result per strobe cycle, no hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable_move <= 1'b0;
            error       <= 1'b0;
        end else begin
            enable_move <= qualified && is_dir && !wall_hit;
            error       <= qualified && is_dir && wall_hit;
        end
    end

endmodule

// File: design/maze_wall_map.sv
/*
    Wall tables of the five built-in 6x6 maze maps.
    Purely combinational, returns the walls of the requested cell.
    Bit order per cell is {left, down, right, up}.
    Unknown maps and off-grid cells read as all walls.
*/
`timescale 1ns/1ps

module maze_wall_map (
    wall_lookup_if.responder lookup
);

    // indexed [map][x][y]
    localparam maze_pkg::cell_walls_t
        WALL_TABLE [maze_pkg::NUM_MAPS][maze_pkg::GRID_SIZE][maze_pkg::GRID_SIZE] = '{
        // map 0
        '{
            // x = 0
            '{4'b0110, 4'b1010,
              4'b0010, 4'b0010,
              4'b0011, 4'b0111},
            // x = 1
            '{4'b1101, 4'b0111,
              4'b1101, 4'b0101,
              4'b0101, 4'b0101},
            // x = 2
            '{4'b0110, 4'b1001,
              4'b0110, 4'b1001,
              4'b1100, 4'b1001},
            // x = 3
            '{4'b1100, 4'b0011,
              4'b0100, 4'b0011,
              4'b0110, 4'b0011},
            // x = 4
            '{4'b0111, 4'b0101,
              4'b1101, 4'b1100,
              4'b1001, 4'b0101},
            // x = 5
            '{4'b1100, 4'b1000,
              4'b1010, 4'b1010,
              4'b1010, 4'b1001}
        },
        // map 1
        '{
            // x = 0
            '{4'b0110, 4'b1010,
              4'b1010, 4'b0010,
              4'b0011, 4'b0111},
            // x = 1
            '{4'b0101, 4'b0110,
              4'b1011, 4'b0101,
              4'b1100, 4'b0001},
            // x = 2
            '{4'b1100, 4'b1001,
              4'b0110, 4'b1001,
              4'b0110, 4'b1001},
            // x = 3
            '{4'b0110, 4'b1010,
              4'b1001, 4'b0110,
              4'b1001, 4'b0111},
            // x = 4
            '{4'b1100, 4'b1011,
              4'b0110, 4'b1001,
              4'b0110, 4'b0001},
            // x = 5
            '{4'b1110, 4'b1010,
              4'b1000, 4'b1010,
              4'b1001, 4'b1101}
        },
        // map 2
        '{
            // x = 0
            '{4'b0110, 4'b1010,
              4'b1010, 4'b1010,
              4'b1010, 4'b0011},
            // x = 1
            '{4'b1100, 4'b1010,
              4'b1010, 4'b0011,
              4'b0110, 4'b1001},
            // x = 2
            '{4'b0110, 4'b1010,
              4'b1010, 4'b1001,
              4'b1100, 4'b1011},
            // x = 3
            '{4'b0101, 4'b0110,
              4'b1010, 4'b1010,
              4'b1010, 4'b0011},
            // x = 4
            '{4'b0101, 4'b1100,
              4'b1010, 4'b0010,
              4'b1011, 4'b0101},
            // x = 5
            '{4'b1100, 4'b1010,
              4'b1010, 4'b1001,
              4'b1110, 4'b1001}
        },
        // map 3
        '{
            // x = 0
            '{4'b1110, 4'b1010,
              4'b0010, 4'b1010,
              4'b0010, 4'b0011},
            // x = 1
            '{4'b0110, 4'b0011,
              4'b0101, 4'b0111,
              4'b0101, 4'b0101},
            // x = 2
            '{4'b1101, 4'b0101,
              4'b0100, 4'b1001,
              4'b0101, 4'b0101},
            // x = 3
            '{4'b0111, 4'b0101,
              4'b0101, 4'b0110,
              4'b1001, 4'b1101},
            // x = 4
            '{4'b0101, 4'b0101,
              4'b1101, 4'b1100,
              4'b1010, 4'b0011},
            // x = 5
            '{4'b1100, 4'b1000,
              4'b1010, 4'b1010,
              4'b1010, 4'b1001}
        },
        // map 4
        '{
            // x = 0
            '{4'b0110, 4'b1010,
              4'b1010, 4'b0011,
              4'b1110, 4'b0011},
            // x = 1
            '{4'b0101, 4'b0111,
              4'b1110, 4'b1001,
              4'b0110, 4'b0001},
            // x = 2
            '{4'b0101, 4'b0100,
              4'b0011, 4'b0110,
              4'b0001, 4'b0101},
            // x = 3
            '{4'b0101, 4'b0101,
              4'b0101, 4'b1101,
              4'b0101, 4'b0101},
            // x = 4
            '{4'b1100, 4'b1001,
              4'b1100, 4'b0011,
              4'b0101, 4'b0101},
            // x = 5
            '{4'b1110, 4'b1010,
              4'b1010, 4'b1000,
              4'b1001, 4'b1101}
        }
    };

    logic map_valid;
    logic cell_valid;

    assign map_valid  = int'(lookup.map_sel) < maze_pkg::NUM_MAPS;
    assign cell_valid = (int'(lookup.pos_x) < maze_pkg::GRID_SIZE) &&
                        (int'(lookup.pos_y) < maze_pkg::GRID_SIZE);

    always_comb begin
        if (map_valid && cell_valid) begin
            lookup.walls = WALL_TABLE[lookup.map_sel][lookup.pos_x][lookup.pos_y];
        end else begin
            // outside the stored maps, every side is closed
            lookup.walls = maze_pkg::ALL_WALLS;
        end
    end

endmodule

// File: design/wall_lookup_if.sv
/*
    Cell lookup between the move checker and the wall map.
    The requester drives map and position, the responder returns
    the four walls of that cell in the same cycle.
*/
`timescale 1ns/1ps

interface wall_lookup_if;

    maze_pkg::map_sel_t    map_sel;
    maze_pkg::coord_t      pos_x;
    maze_pkg::coord_t      pos_y;
    maze_pkg::cell_walls_t walls;

    modport requester (
        output map_sel, pos_x, pos_y,
        input  walls
    );

    modport responder (
        input  map_sel, pos_x, pos_y,
        output walls
    );

endinterface

// File: design/maze_pkg.sv
/*
    Shared definitions for the maze wall detector.
    Grid and map sizes, button codes and wall direction indices.
    Referenced by scoped name from the RTL and the testbench.
*/
package maze_pkg;

    // grid and stored map count, fixed by the wall tables
    localparam int GRID_SIZE = 6;
    localparam int NUM_MAPS  = 5;

    // cell coordinate, 0 to 5 on the grid
    typedef logic [2:0] coord_t;

    // map number, 0 to 4 valid
    typedef logic [2:0] map_sel_t;

    typedef enum logic [2:0] {
        MODE_SELECT = 3'd0,
        MAZE        = 3'd1
    } play_mode_t;

    // one-hot button code
    typedef logic [5:0] button_t;

    localparam button_t BTN_NONE   = 6'b000000;
    localparam button_t BTN_SELECT = 6'b000001;
    localparam button_t BTN_UP     = 6'b000010;
    localparam button_t BTN_RIGHT  = 6'b000100;
    localparam button_t BTN_DOWN   = 6'b001000;
    localparam button_t BTN_LEFT   = 6'b010000;
    localparam button_t BTN_BACK   = 6'b100000;

    // wall index within a cell
    typedef enum logic [1:0] {
        UP    = 2'd0,
        RIGHT = 2'd1,
        DOWN  = 2'd2,
        LEFT  = 2'd3
    } dir_e;

    // one bit per dir_e index, 1 = wall
    typedef logic [3:0] cell_walls_t;

    localparam cell_walls_t ALL_WALLS = 4'b1111;

endpackage
